/* Makefile */
VERILATOR ?= verilator
TOP       ?= vending_tb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_MSG  ?= Simulation failed
PASS_MSG  ?= Simulation passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "test failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "run ended early, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* files.f */
hw/vend_pkg.sv
hw/coin_if.sv
hw/tick_timer.sv
hw/coin_conditioner.sv
hw/vend_fsm.sv
hw/credit_register.sv
hw/money_display.sv
hw/vending_top.sv
testbench/vending_asserts.sv
testbench/vending_tb.sv

/* hw/coin_conditioner.sv */
`timescale 1ns/1ps
`default_nettype none

module coin_conditioner #(
    parameter int DEBOUNCE_LEN = 4
) (
    input  logic clk,
    input  logic rst_op,
    input  logic sample_tick,
    input  logic btn_coin_5,
    input  logic btn_coin_10,
    input  logic btn_coin_50,
    input  logic btn_cancel,
    coin_if.source coins
);

    logic [3:0] btn_raw;
    logic [DEBOUNCE_LEN-1:0] shift_q [4];
    logic [3:0] level_db;
    logic [3:0] level_prev;
    logic [3:0] pulse_q;

    assign btn_raw = {btn_cancel, btn_coin_50, btn_coin_10, btn_coin_5};

    // debounced level needs every sample high
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            level_db[i] = &shift_q[i];
        end
    end

    always_ff @(posedge clk) begin
        if (rst_op) begin
            for (int i = 0; i < 4; i++) begin
                shift_q[i] <= '0;
            end
            level_prev <= '0;
            pulse_q    <= '0;
        end else begin
            // sample only on the slow tick
            if (sample_tick) begin
                for (int i = 0; i < 4; i++) begin
                    shift_q[i] <= (shift_q[i] << 1) | DEBOUNCE_LEN'(btn_raw[i]);
                end
            end
            // edge detect runs every clock so the pulse is one cycle wide
            pulse_q    <= level_db & ~level_prev;
            level_prev <= level_db;
        end
    end

    assign coins.coin_5  = pulse_q[0];
    assign coins.coin_10 = pulse_q[1];
    assign coins.coin_50 = pulse_q[2];
    assign coins.cancel  = pulse_q[3];

endmodule

`default_nettype wire

/* hw/coin_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface coin_if;

    // one-cycle pulses from the button conditioner
    logic coin_5;
    logic coin_10;
    logic coin_50;
    logic cancel;

    modport source (output coin_5, output coin_10, output coin_50, output cancel);

    modport sink (input coin_5, input coin_10, input coin_50, input cancel);

endinterface

`default_nettype wire

/* hw/credit_register.sv */
`timescale 1ns/1ps
`default_nettype none

module credit_register (
    input  logic clk,
    input  logic rst_op,
    input  vend_pkg::credit_op_e op,
    input  logic [vend_pkg::CREDIT_W-1:0] amount,
    output logic [vend_pkg::CREDIT_W-1:0] credit,
    output logic [3:0] led_affordable
);

    import vend_pkg::*;

    // one extra bit so the carry is visible
    logic [CREDIT_W:0] sum;

    assign sum = {1'b0, credit} + {1'b0, amount};

    always_ff @(posedge clk) begin
        if (rst_op) begin
            credit <= '0;
        end else begin
            unique case (op)
                op_add: begin
                    // saturate at the display limit
                    if (sum > CREDIT_MAX) begin
                        credit <= CREDIT_MAX;
                    end else begin
                        credit <= sum[CREDIT_W-1:0];
                    end
                end
                op_deduct: begin
                    if (amount > credit) begin
                        credit <= '0;
                    end else begin
                        credit <= credit - amount;
                    end
                end
                op_clear: credit <= '0;
                default:  credit <= credit;
            endcase
        end
    end

    // one LED per drink
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            led_affordable[i] = (credit >= drink_price[i]);
        end
    end

endmodule

`default_nettype wire

/* hw/money_display.sv */
`timescale 1ns/1ps
`default_nettype none

module money_display (
    input  logic clk,
    input  logic rst_op,
    input  logic scan_tick,
    input  logic [vend_pkg::CREDIT_W-1:0] credit,
    output logic [3:0] an,
    output logic [7:0] seg
);

    logic digit_sel;
    logic [3:0] tens;
    logic [3:0] ones;
    logic [3:0] digit;

    // active-low segments with dp in the lsb
    function automatic logic [7:0] seg_encode(input logic [3:0] d);
        case (d)
            4'd0:    seg_encode = 8'b00000011;
            4'd1:    seg_encode = 8'b10011111;
            4'd2:    seg_encode = 8'b00100101;
            4'd3:    seg_encode = 8'b00001101;
            4'd4:    seg_encode = 8'b10011001;
            4'd5:    seg_encode = 8'b01001001;
            4'd6:    seg_encode = 8'b01000001;
            4'd7:    seg_encode = 8'b00011111;
            4'd8:    seg_encode = 8'b00000001;
            4'd9:    seg_encode = 8'b00001001;
            default: seg_encode = 8'b01100000;
        endcase
    endfunction

    // credit never exceeds 99
    assign tens = 4'(credit / 10);
    assign ones = 4'(credit % 10);

    // 0 shows ones, 1 shows tens
    always_ff @(posedge clk) begin
        if (rst_op) begin
            digit_sel <= 1'b0;
        end else if (scan_tick) begin
            digit_sel <= ~digit_sel;
        end
    end

    assign an    = digit_sel ? 4'b1101 : 4'b1110;
    assign digit = digit_sel ? tens : ones;
    assign seg   = seg_encode(digit);

endmodule

`default_nettype wire

/* hw/tick_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module tick_timer #(
    parameter int DIV = 100_000
) (
    input  logic clk,
    input  logic rst_op,
    output logic tick
);

    localparam int CNT_W = (DIV > 1) ? $clog2(DIV) : 1;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(DIV - 1);

    logic [CNT_W-1:0] cnt;

    // wraps at DIV-1
    always_ff @(posedge clk) begin
        if (rst_op) begin
            cnt <= '0;
        end else if (cnt == CNT_LAST) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // one cycle per period
    assign tick = (cnt == CNT_LAST);

endmodule

`default_nettype wire

/* hw/vend_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module vend_fsm (
    input  logic clk,
    input  logic rst_op,
    coin_if.sink coins,
    input  logic [3:0] select,
    input  logic [vend_pkg::CREDIT_W-1:0] credit,
    output vend_pkg::credit_op_e op,
    output logic [vend_pkg::CREDIT_W-1:0] amount,
    output logic vend_valid,
    output logic [3:0] vend_drink,
    output logic refund_valid,
    output logic [vend_pkg::CREDIT_W-1:0] refund_amount
);

    import vend_pkg::*;

    vend_state_e state;
    logic [1:0] sel_idx;
    logic [CREDIT_W-1:0] sel_price;
    logic sel_ok;
    logic coin_hit;
    logic [CREDIT_W-1:0] coin_value;

    // lowest-numbered selected drink wins
    always_comb begin
        sel_idx = 2'd0;
        for (int i = 3; i >= 0; i--) begin
            if (select[i]) begin
                sel_idx = 2'(i);
            end
        end
    end

    assign sel_price = drink_price[sel_idx];
    assign sel_ok    = (|select) && (credit >= sel_price);
    assign coin_hit  = coins.coin_5 | coins.coin_10 | coins.coin_50;

    always_comb begin
        if (coins.coin_5) begin
            coin_value = COIN_5;
        end else if (coins.coin_10) begin
            coin_value = COIN_10;
        end else begin
            coin_value = COIN_50;
        end
    end

    // vend and refund last one cycle, then back to insert
    always_ff @(posedge clk) begin
        if (rst_op) begin
            state        <= st_insert;
            op           <= op_none;
            vend_valid   <= 1'b0;
            refund_valid <= 1'b0;
        end else begin
            state        <= st_insert;
            op           <= op_none;
            vend_valid   <= 1'b0;
            refund_valid <= 1'b0;
            if (state == st_insert) begin
                // cancel beats select beats coin
                if (coins.cancel) begin
                    state        <= st_refund;
                    refund_valid <= 1'b1;
                    op           <= op_clear;
                end else if (sel_ok) begin
                    state      <= st_vend;
                    vend_valid <= 1'b1;
                    op         <= op_deduct;
                end else if (coin_hit) begin
                    op <= op_add;
                end
            end
        end
    end

    // payload alongside the strobes
    always_ff @(posedge clk) begin
        if (state == st_insert) begin
            amount        <= sel_ok ? sel_price : coin_value;
            vend_drink    <= 4'b0001 << sel_idx;
            refund_amount <= credit;
        end
    end

endmodule

`default_nettype wire

/* hw/vend_pkg.sv */
`default_nettype none

package vend_pkg;

    // credit value range
    localparam int CREDIT_W = 8;
    localparam logic [CREDIT_W-1:0] CREDIT_MAX = 8'd99;

    // coin denominations
    localparam logic [7:0] COIN_5  = 8'd5;
    localparam logic [7:0] COIN_10 = 8'd10;
    localparam logic [7:0] COIN_50 = 8'd50;

    // price of drinks 0 to 3
    localparam logic [7:0] drink_price [4] = '{8'd20, 8'd25, 8'd30, 8'd60};

    typedef enum logic [1:0] {
        st_insert,
        st_vend,
        st_refund
    } vend_state_e;

    // credit register commands
    typedef enum logic [1:0] {
        op_none,
        op_add,
        op_deduct,
        op_clear
    } credit_op_e;

endpackage

`default_nettype wire

/* hw/vending_top.sv */
`timescale 1ns/1ps
`default_nettype none

module vending_top #(
    parameter int DEBOUNCE_DIV = 100_000,
    parameter int DEBOUNCE_LEN = 4,
    parameter int SCAN_DIV     = 100_000
) (
    input  logic clk,
    input  logic rst_op,
    input  logic btn_coin_5,
    input  logic btn_coin_10,
    input  logic btn_coin_50,
    input  logic btn_cancel,
    input  logic [3:0] select,
    output logic [7:0] seg,
    output logic [3:0] an,
    output logic [3:0] led_affordable,
    output logic vend_valid,
    output logic [3:0] vend_drink,
    output logic refund_valid,
    output logic [7:0] refund_amount
);

    import vend_pkg::*;

    logic sample_tick;
    logic scan_tick;
    credit_op_e op;
    logic [CREDIT_W-1:0] amount;
    logic [CREDIT_W-1:0] credit;

    coin_if coins ();

    // slow tick for button sampling
    tick_timer #(.DIV(DEBOUNCE_DIV)) i_sample_timer (
        .clk    (clk),
        .rst_op (rst_op),
        .tick   (sample_tick)
    );

    // digit multiplex rate
    tick_timer #(.DIV(SCAN_DIV)) i_scan_timer (
        .clk    (clk),
        .rst_op (rst_op),
        .tick   (scan_tick)
    );

    coin_conditioner #(.DEBOUNCE_LEN(DEBOUNCE_LEN)) i_coin_conditioner (
        .clk         (clk),
        .rst_op      (rst_op),
        .sample_tick (sample_tick),
        .btn_coin_5  (btn_coin_5),
        .btn_coin_10 (btn_coin_10),
        .btn_coin_50 (btn_coin_50),
        .btn_cancel  (btn_cancel),
        .coins       (coins)
    );

    vend_fsm i_vend_fsm (
        .clk           (clk),
        .rst_op        (rst_op),
        .coins         (coins),
        .select        (select),
        .credit        (credit),
        .op            (op),
        .amount        (amount),
        .vend_valid    (vend_valid),
        .vend_drink    (vend_drink),
        .refund_valid  (refund_valid),
        .refund_amount (refund_amount)
    );

    credit_register i_credit_register (
        .clk            (clk),
        .rst_op         (rst_op),
        .op             (op),
        .amount         (amount),
        .credit         (credit),
        .led_affordable (led_affordable)
    );

    money_display i_money_display (
        .clk       (clk),
        .rst_op    (rst_op),
        .scan_tick (scan_tick),
        .credit    (credit),
        .an        (an),
        .seg       (seg)
    );

endmodule

`default_nettype wire

/* testbench/vending_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module vending_asserts (
    input logic clk,
    input logic rst_op,
    input logic vend_valid,
    input logic [3:0] vend_drink,
    input logic refund_valid,
    input logic [vend_pkg::CREDIT_W-1:0] credit
);

    import vend_pkg::*;

    // vend and refund never overlap
    vend_refund_exclusive: assert property (
        @(posedge clk) disable iff (rst_op) !(vend_valid && refund_valid)
    ) else $error("vend_valid and refund_valid high in the same cycle");

    drink_one_hot: assert property (
        @(posedge clk) disable iff (rst_op) vend_valid |-> $onehot(vend_drink)
    ) else $error("vend_drink is not one-hot during a vend");

    // saturation limit of the credit
    credit_capped: assert property (
        @(posedge clk) disable iff (rst_op) credit <= CREDIT_MAX
    ) else $error("credit is above the limit");

endmodule

bind vend_fsm vending_asserts i_vending_asserts (
    .clk          (clk),
    .rst_op       (rst_op),
    .vend_valid   (vend_valid),
    .vend_drink   (vend_drink),
    .refund_valid (refund_valid),
    .credit       (credit)
);

`default_nettype wire

/* testbench/vending_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module vending_tb;

    localparam int WAIT_LIMIT = 40;

    logic clk;
    logic rst_op;
    logic btn_coin_5;
    logic btn_coin_10;
    logic btn_coin_50;
    logic btn_cancel;
    logic [3:0] select;
    logic [7:0] seg;
    logic [3:0] an;
    logic [3:0] led_affordable;
    logic vend_valid;
    logic [3:0] vend_drink;
    logic refund_valid;
    logic [7:0] refund_amount;

    // prices, coin values and segment patterns
    int price [4] = '{20, 25, 30, 60};
    int coin_value [3] = '{5, 10, 50};
    logic [7:0] seg_table [10] = '{8'b00000011, 8'b10011111, 8'b00100101, 8'b00001101,
                                   8'b10011001, 8'b01001001, 8'b01000001, 8'b00011111,
                                   8'b00000001, 8'b00001001};

    integer seed;
    int error_count = 0;
    int check_count = 0;
    int model_credit = 0;
    int refund_count = 0;
    logic [7:0] refund_seen;

    vending_top #(
        .DEBOUNCE_DIV (4),
        .DEBOUNCE_LEN (4),
        .SCAN_DIV     (8)
    ) i_vending_top (
        .clk            (clk),
        .rst_op         (rst_op),
        .btn_coin_5     (btn_coin_5),
        .btn_coin_10    (btn_coin_10),
        .btn_coin_50    (btn_coin_50),
        .btn_cancel     (btn_cancel),
        .select         (select),
        .seg            (seg),
        .an             (an),
        .led_affordable (led_affordable),
        .vend_valid     (vend_valid),
        .vend_drink     (vend_drink),
        .refund_valid   (refund_valid),
        .refund_amount  (refund_amount)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // strobes must never coincide
    always @(negedge clk) begin
        if (!rst_op && vend_valid && refund_valid) begin
            error_count++;
            $display("vend_valid and refund_valid were high in the same cycle");
        end
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("ERROR: %s is 0x%0h, expected 0x%0h", name, actual, expected);
        end
    endtask

    function automatic int lowest_drink(input logic [3:0] mask);
        for (int i = 0; i < 4; i++) begin
            if (mask[i]) begin
                return i;
            end
        end
        return 0;
    endfunction

    task automatic set_button(input int which, input logic level);
        case (which)
            0: btn_coin_5 = level;
            1: btn_coin_10 = level;
            2: btn_coin_50 = level;
            default: btn_cancel = level;
        endcase
    endtask

    // hold a button and watch for a refund meanwhile
    task automatic press_button(input int which, input int hold_cycles);
        @(posedge clk);
        #2;
        set_button(which, 1'b1);
        for (int n = 0; n < hold_cycles; n++) begin
            @(negedge clk);
            if (refund_valid) begin
                refund_count++;
                refund_seen = refund_amount;
            end
        end
        @(posedge clk);
        #2;
        set_button(which, 1'b0);
        // debouncer drops back before the next press
        repeat (12) @(posedge clk);
    endtask

    task automatic pulse_select(input logic [3:0] mask);
        @(posedge clk);
        #2;
        select = mask;
        @(posedge clk);
        #2;
        select = 4'b0000;
    endtask

    task automatic wait_for_anode(input logic [3:0] want);
        for (int n = 0; n < WAIT_LIMIT; n++) begin
            @(negedge clk);
            if (an === want) begin
                return;
            end
        end
        error_count++;
        $display("digit select never reached %b", want);
    endtask

    // LEDs and both display digits
    task automatic check_credit(input int expected);
        logic [3:0] exp_led;
        for (int i = 0; i < 4; i++) begin
            exp_led[i] = (expected >= price[i]);
        end
        wait_for_anode(4'b1110);
        check_value("led_affordable", led_affordable, exp_led);
        check_value("seg ones", seg, seg_table[expected % 10]);
        wait_for_anode(4'b1101);
        check_value("seg tens", seg, seg_table[expected / 10]);
    endtask

    task automatic add_coin(input int which, input int hold_cycles);
        press_button(which, hold_cycles);
        model_credit = model_credit + coin_value[which];
        if (model_credit > 99) begin
            model_credit = 99;
        end
        check_credit(model_credit);
    endtask

    task automatic verify_reset_state();
        @(negedge clk);
        check_value("an", an, 4'b1110);
        check_value("seg", seg, seg_table[0]);
        check_value("led_affordable", led_affordable, 4'b0000);
        check_value("vend_valid", vend_valid, 1'b0);
        check_value("refund_valid", refund_valid, 1'b0);
    endtask

    task automatic insert_random_coins();
        int which;
        for (int k = 0; k < 7; k++) begin
            which = $unsigned($random(seed)) % 3;
            add_coin(which, 40);
        end
        // two large coins force the cap
        add_coin(2, 40);
        add_coin(2, 40);
    endtask

    task automatic vend_affordable_drink(input logic [3:0] mask);
        int idx;
        bit seen;
        idx = lowest_drink(mask);
        seen = 1'b0;
        pulse_select(mask);
        for (int n = 0; n < WAIT_LIMIT && !seen; n++) begin
            @(negedge clk);
            if (vend_valid) begin
                seen = 1'b1;
                check_value("vend_drink", vend_drink, 4'b0001 << idx);
            end
        end
        if (!seen) begin
            error_count++;
            $display("no vend after selecting drink %0d", idx);
        end
        model_credit = model_credit - price[idx];
        check_credit(model_credit);
    endtask

    task automatic reject_costly_drink(input logic [3:0] mask);
        pulse_select(mask);
        for (int n = 0; n < WAIT_LIMIT; n++) begin
            @(negedge clk);
            if (vend_valid) begin
                error_count++;
                $display("vend on a select with too little credit");
            end
        end
        check_credit(model_credit);
    endtask

    task automatic refund_credit();
        refund_count = 0;
        press_button(3, 40);
        check_value("refund pulses", refund_count, 1);
        check_value("refund_amount", refund_seen, model_credit);
        model_credit = 0;
        check_credit(0);
    endtask

    initial begin
        seed = 32'hb842_9c98;
        rst_op = 1'b1;
        btn_coin_5 = 1'b0;
        btn_coin_10 = 1'b0;
        btn_coin_50 = 1'b0;
        btn_cancel = 1'b0;
        select = 4'b0000;
        repeat (2) @(posedge clk);
        #2;
        rst_op = 1'b0;

        verify_reset_state();
        insert_random_coins();
        vend_affordable_drink(4'b1000);
        // with two drinks selected the lower one wins
        vend_affordable_drink(4'b0110);
        reject_costly_drink(4'b1000);
        refund_credit();
        // long press still adds only once
        add_coin(1, 200);

        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
